// File: Bender.yml
package:
  name: goomba_enemy

sources:
  - hw/enemy_pkg.sv
  - hw/nearest_player.sv
  - hw/terrain_check.sv
  - hw/goomba_walker.sv
  - hw/sprite_pixel.sv
  - hw/goomba_enemy.sv
  - target: test
    files:
      - verification/goomba_assert.sv
      - verification/goomba_tb.sv

// File: build.f
hw/enemy_pkg.sv
hw/nearest_player.sv
hw/terrain_check.sv
hw/goomba_walker.sv
hw/sprite_pixel.sv
hw/goomba_enemy.sv
verification/goomba_assert.sv
verification/goomba_tb.sv

// File: hw/enemy_pkg.sv
package enemy_pkg;

    // screen and world positions share one width
    typedef logic [9:0]  xcoord_t;
    typedef logic [23:0] rgb_t;
    // dwell and death ticks use the same counter
    typedef logic [2:0]  tick_cnt_t;

    typedef enum logic [2:0] {
        WALK_L1,
        WALK_L2,
        WALK_R1,
        WALK_R2,
        DYING,
        GONE
    } walk_state_e;

    typedef enum logic {
        SIDE_LEFT,
        SIDE_RIGHT
    } side_t;

    typedef struct packed {
        logic at_scroll_edge;
        logic at_limit;
        logic blocked;
    } terrain_flags_t;

    typedef struct packed {
        xcoord_t x;
        logic    frame_b;
        logic    dying;
        logic    gone;
    } enemy_view_t;

    localparam int SPRITE_SIZE = 32;
    localparam int STEP        = 2;
    localparam xcoord_t GROUND_Y = 10'd384;

    // pipe zones, right edge must pass LO and x must be below HI
    localparam xcoord_t PIPE1_LO = 10'd101;
    localparam xcoord_t PIPE1_HI = 10'd161;
    // x + 26 past 641 is the same as the right edge past 647
    localparam xcoord_t PIPE2_LO = 10'd647;
    localparam xcoord_t PIPE2_HI = 10'd701;

    localparam int DWELL_TICKS = 4;
    localparam int DEATH_TICKS = 4;

endpackage

// File: hw/goomba_enemy.sv
`timescale 1ns/10ps

module goomba_enemy #(
    parameter enemy_pkg::xcoord_t X_ORIGIN = 10'd400,
    parameter enemy_pkg::xcoord_t X_LIMIT  = 10'd1023
) (
    input  logic               Clk,
    input  logic               rst_n,
    input  logic               frame_tick,
    input  enemy_pkg::xcoord_t mario_x,
    input  enemy_pkg::xcoord_t luigi_x,
    input  enemy_pkg::xcoord_t scroll_x,
    input  logic               alive,
    input  enemy_pkg::xcoord_t draw_x,
    input  enemy_pkg::xcoord_t draw_y,
    input  enemy_pkg::rgb_t    pic_a,
    input  enemy_pkg::rgb_t    pic_b,
    input  enemy_pkg::rgb_t    pic_dead,
    output logic               hit,
    output enemy_pkg::xcoord_t enemy_x,
    output enemy_pkg::xcoord_t enemy_y,
    output enemy_pkg::rgb_t    pixel
);

    enemy_pkg::side_t          target_side;
    enemy_pkg::terrain_flags_t terrain;
    enemy_pkg::enemy_view_t    view;

    // no vertical motion, always on the ground row
    assign enemy_x = view.x;
    assign enemy_y = enemy_pkg::GROUND_Y;

    nearest_player u_nearest (
        .mario_x     (mario_x),
        .luigi_x     (luigi_x),
        .enemy_x     (enemy_x),
        .target_side (target_side)
    );

    terrain_check #(.X_LIMIT(X_LIMIT)) u_terrain (
        .enemy_x  (enemy_x),
        .scroll_x (scroll_x),
        .terrain  (terrain)
    );

    goomba_walker #(.X_ORIGIN(X_ORIGIN), .X_LIMIT(X_LIMIT)) u_walker (
        .Clk         (Clk),
        .rst_n       (rst_n),
        .frame_tick  (frame_tick),
        .alive       (alive),
        .target_side (target_side),
        .terrain     (terrain),
        .view        (view)
    );

    sprite_pixel u_pixel (
        .Clk      (Clk),
        .rst_n    (rst_n),
        .view     (view),
        .scroll_x (scroll_x),
        .draw_x   (draw_x),
        .draw_y   (draw_y),
        .pic_a    (pic_a),
        .pic_b    (pic_b),
        .pic_dead (pic_dead),
        .hit      (hit),
        .pixel    (pixel)
    );

endmodule

// File: hw/goomba_walker.sv
`timescale 1ns/10ps

module goomba_walker #(
    parameter enemy_pkg::xcoord_t X_ORIGIN = 10'd400,
    parameter enemy_pkg::xcoord_t X_LIMIT  = 10'd1023
) (
    input  logic                      Clk,
    input  logic                      rst_n,
    input  logic                      frame_tick,
    input  logic                      alive,
    input  enemy_pkg::side_t          target_side,
    input  enemy_pkg::terrain_flags_t terrain,
    output enemy_pkg::enemy_view_t    view
);

    enemy_pkg::walk_state_e state_q;
    enemy_pkg::walk_state_e state_d;
    enemy_pkg::tick_cnt_t   cnt_q;
    enemy_pkg::tick_cnt_t   cnt_d;
    enemy_pkg::xcoord_t     pos_x_q;
    enemy_pkg::xcoord_t     pos_x_d;

    logic               walking;
    logic               frame_b;
    logic               do_move;
    enemy_pkg::side_t   move_side;
    logic [10:0]        x_right;
    enemy_pkg::xcoord_t x_left;

    assign walking = (state_q == enemy_pkg::WALK_L1) || (state_q == enemy_pkg::WALK_L2) ||
                     (state_q == enemy_pkg::WALK_R1) || (state_q == enemy_pkg::WALK_R2);

    assign frame_b = (state_q == enemy_pkg::WALK_L2) || (state_q == enemy_pkg::WALK_R2);

    // one step either way, right side widened for the clamp
    assign x_right = {1'b0, pos_x_q} + 11'(enemy_pkg::STEP);
    assign x_left  = (pos_x_q < enemy_pkg::STEP) ? '0 :
                     pos_x_q - enemy_pkg::xcoord_t'(enemy_pkg::STEP);

    always_comb
    begin
        state_d   = state_q;
        cnt_d     = cnt_q;
        pos_x_d   = pos_x_q;
        do_move   = 1'b0;
        move_side = enemy_pkg::SIDE_LEFT;

        if (frame_tick)
        begin
            if (walking && !alive)
            begin
                state_d = enemy_pkg::DYING;
                cnt_d   = '0;
            end
            else if (walking)
            begin
                if (terrain.at_scroll_edge)
                begin
                    do_move   = 1'b1;
                    move_side = enemy_pkg::SIDE_RIGHT;
                end
                else if (terrain.at_limit)
                begin
                    do_move   = 1'b1;
                    move_side = enemy_pkg::SIDE_LEFT;
                end
                else if (cnt_q == enemy_pkg::DWELL_TICKS - 1)
                begin
                    // dwell over, re-aim at the nearer player
                    cnt_d     = '0;
                    do_move   = 1'b1;
                    move_side = target_side;
                end
                else
                    cnt_d = cnt_q + 1'b1;
            end
            else if (state_q == enemy_pkg::DYING)
            begin
                if (cnt_q == enemy_pkg::DEATH_TICKS - 1)
                    state_d = enemy_pkg::GONE;
                else
                    cnt_d = cnt_q + 1'b1;
            end
        end

        if (do_move)
        begin
            // feet alternate even when a pipe holds the enemy back
            if (move_side == enemy_pkg::SIDE_RIGHT)
                state_d = frame_b ? enemy_pkg::WALK_R1 : enemy_pkg::WALK_R2;
            else
                state_d = frame_b ? enemy_pkg::WALK_L1 : enemy_pkg::WALK_L2;

            if (!terrain.blocked)
            begin
                if (move_side == enemy_pkg::SIDE_RIGHT)
                    pos_x_d = (x_right >= X_LIMIT) ? X_LIMIT : x_right[9:0];
                else
                    pos_x_d = x_left;
            end
        end
    end

    always_ff @(posedge Clk)
    begin
        if (!rst_n)
        begin
            state_q <= enemy_pkg::WALK_L1;
            cnt_q   <= '0;
            pos_x_q <= X_ORIGIN;
        end
        else
        begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
            pos_x_q <= pos_x_d;
        end
    end

    // a vanished enemy reports x as 0
    always_comb
    begin
        view.x       = (state_q == enemy_pkg::GONE) ? '0 : pos_x_q;
        view.frame_b = frame_b;
        view.dying   = (state_q == enemy_pkg::DYING);
        view.gone    = (state_q == enemy_pkg::GONE);
    end

endmodule

// File: hw/nearest_player.sv
`timescale 1ns/10ps

module nearest_player (
    input  enemy_pkg::xcoord_t mario_x,
    input  enemy_pkg::xcoord_t luigi_x,
    input  enemy_pkg::xcoord_t enemy_x,
    output enemy_pkg::side_t   target_side
);

    enemy_pkg::xcoord_t mario_dist;
    enemy_pkg::xcoord_t luigi_dist;
    enemy_pkg::xcoord_t chosen_x;

    // absolute distances to the enemy
    always_comb
    begin
        if (mario_x < enemy_x)
            mario_dist = enemy_x - mario_x;
        else
            mario_dist = mario_x - enemy_x;

        if (luigi_x < enemy_x)
            luigi_dist = enemy_x - luigi_x;
        else
            luigi_dist = luigi_x - enemy_x;
    end

    // mario wins a tie
    assign chosen_x = (mario_dist <= luigi_dist) ? mario_x : luigi_x;

    always_comb
    begin
        if (chosen_x < enemy_x)
            target_side = enemy_pkg::SIDE_LEFT;
        else
            target_side = enemy_pkg::SIDE_RIGHT;
    end

endmodule

// File: hw/sprite_pixel.sv
`timescale 1ns/10ps

module sprite_pixel (
    input  logic                   Clk,
    input  logic                   rst_n,
    input  enemy_pkg::enemy_view_t view,
    input  enemy_pkg::xcoord_t     scroll_x,
    input  enemy_pkg::xcoord_t     draw_x,
    input  enemy_pkg::xcoord_t     draw_y,
    input  enemy_pkg::rgb_t        pic_a,
    input  enemy_pkg::rgb_t        pic_b,
    input  enemy_pkg::rgb_t        pic_dead,
    output logic                   hit,
    output enemy_pkg::rgb_t        pixel
);

    logic [10:0]     world_x;
    logic [10:0]     box_right;
    logic            hit_d;
    enemy_pkg::rgb_t pixel_d;

    // draw position in world coordinates, no wrap
    assign world_x   = draw_x + scroll_x;
    assign box_right = view.x + 11'(enemy_pkg::SPRITE_SIZE);

    assign hit_d = !view.gone &&
                   (view.x < world_x) && (world_x < box_right) &&
                   (draw_y > enemy_pkg::GROUND_Y) &&
                   (draw_y < enemy_pkg::GROUND_Y + enemy_pkg::SPRITE_SIZE);

    always_comb
    begin
        if (view.gone)
            pixel_d = '0;
        else if (view.dying)
            pixel_d = pic_dead;
        else if (view.frame_b)
            pixel_d = pic_b;
        else
            pixel_d = pic_a;
    end

    always_ff @(posedge Clk)
    begin
        if (!rst_n)
        begin
            hit   <= 1'b0;
            pixel <= '0;
        end
        else
        begin
            hit   <= hit_d;
            pixel <= pixel_d;
        end
    end

endmodule

// File: hw/terrain_check.sv
`timescale 1ns/10ps

module terrain_check #(
    parameter enemy_pkg::xcoord_t X_LIMIT = 10'd1023
) (
    input  enemy_pkg::xcoord_t        enemy_x,
    input  enemy_pkg::xcoord_t        scroll_x,
    output enemy_pkg::terrain_flags_t terrain
);

    logic [10:0] right_edge;
    logic        in_pipe1;
    logic        in_pipe2;

    // widened so the edge near 1023 does not wrap
    assign right_edge = enemy_x + 11'(enemy_pkg::SPRITE_SIZE);

    assign in_pipe1 = (right_edge > enemy_pkg::PIPE1_LO) &&
                      (enemy_x < enemy_pkg::PIPE1_HI);

    assign in_pipe2 = (right_edge > enemy_pkg::PIPE2_LO) &&
                      (enemy_x < enemy_pkg::PIPE2_HI);

    always_comb
    begin
        // left edge of the scrolled view
        terrain.at_scroll_edge = (enemy_x <= scroll_x);
        terrain.at_limit       = (right_edge >= X_LIMIT);
        // enemy is always on the ground row, so only x matters
        terrain.blocked        = in_pipe1 || in_pipe2;
    end

endmodule

// File: verification/goomba_assert.sv
`timescale 1ns/10ps

module goomba_walker_assert (
    input logic                   Clk,
    input logic                   rst_n,
    input logic                   frame_tick,
    input enemy_pkg::walk_state_e state_q,
    input enemy_pkg::xcoord_t     pos_x_q
);

    int fail_count = 0;

    // position only moves on a frame tick
    hold_without_tick: assert property (@(posedge Clk) disable iff (!rst_n)
        !frame_tick |=> $stable(pos_x_q))
    else
    begin
        $error("walker x changed without frame_tick");
        fail_count++;
    end

    step_bounded: assert property (@(posedge Clk) disable iff (!rst_n)
        frame_tick |=> ((pos_x_q - $past(pos_x_q) <= enemy_pkg::STEP) ||
                        ($past(pos_x_q) - pos_x_q <= enemy_pkg::STEP)))
    else
    begin
        $error("walker x moved more than one step");
        fail_count++;
    end

    // terminal until reset
    gone_is_final: assert property (@(posedge Clk) disable iff (!rst_n)
        (state_q == enemy_pkg::GONE) |=> (state_q == enemy_pkg::GONE))
    else
    begin
        $error("walker left GONE without reset");
        fail_count++;
    end

endmodule

bind goomba_walker goomba_walker_assert u_walker_assert (
    .Clk        (Clk),
    .rst_n      (rst_n),
    .frame_tick (frame_tick),
    .state_q    (state_q),
    .pos_x_q    (pos_x_q)
);

// File: verification/goomba_tb.sv
`timescale 1ns/10ps

module goomba_tb;

    localparam int X_LIM  = 1023;
    localparam int N_ROWS = 7;

    typedef struct packed {
        enemy_pkg::xcoord_t mario;
        enemy_pkg::xcoord_t luigi;
        enemy_pkg::xcoord_t scroll;
        logic               alive;
        logic [9:0]         ticks;
    } row_t;

    // predicted walker state
    typedef struct packed {
        enemy_pkg::xcoord_t x;
        logic               frame_b;
        logic               dying;
        logic               gone;
        logic [3:0]         cnt;
    } model_t;

    logic               Clk;
    logic               rst_n;
    logic               frame_tick;
    logic               alive;
    enemy_pkg::xcoord_t mario_x;
    enemy_pkg::xcoord_t luigi_x;
    enemy_pkg::xcoord_t scroll_x;
    enemy_pkg::xcoord_t draw_x;
    enemy_pkg::xcoord_t draw_y;
    enemy_pkg::rgb_t    pic_a;
    enemy_pkg::rgb_t    pic_b;
    enemy_pkg::rgb_t    pic_dead;
    logic               hit;
    enemy_pkg::xcoord_t enemy_x;
    enemy_pkg::xcoord_t enemy_y;
    enemy_pkg::xcoord_t lim_x;
    enemy_pkg::rgb_t    pixel;

    row_t   rows [N_ROWS];
    string  row_name [N_ROWS];
    model_t m_main;
    model_t m_lim;
    int     n_checks;
    int     n_errors;

    goomba_enemy dut (
        .Clk(Clk), .rst_n(rst_n), .frame_tick(frame_tick),
        .mario_x(mario_x), .luigi_x(luigi_x), .scroll_x(scroll_x), .alive(alive),
        .draw_x(draw_x), .draw_y(draw_y),
        .pic_a(pic_a), .pic_b(pic_b), .pic_dead(pic_dead),
        .hit(hit), .enemy_x(enemy_x), .enemy_y(enemy_y), .pixel(pixel)
    );

    // starts inside the right limit and turns left on its first ticks
    goomba_enemy #(.X_ORIGIN(10'd1000)) dut_near_limit (
        .Clk(Clk), .rst_n(rst_n), .frame_tick(frame_tick),
        .mario_x(mario_x), .luigi_x(luigi_x), .scroll_x(scroll_x), .alive(alive),
        .draw_x(draw_x), .draw_y(draw_y),
        .pic_a(pic_a), .pic_b(pic_b), .pic_dead(pic_dead),
        .hit(), .enemy_x(lim_x), .enemy_y(), .pixel()
    );

    initial
    begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    initial
    begin
        #200000;
        $display("timeout: run did not reach its end within 200 us");
        $display("Test failed");
        $finish;
    end

    function automatic model_t next_model(model_t m, enemy_pkg::xcoord_t mx,
                                          enemy_pkg::xcoord_t lx, enemy_pkg::xcoord_t sx,
                                          logic alv);
        model_t n;
        int     xi;
        int     dist_m;
        int     dist_l;
        logic   move;
        logic   go_right;
        logic   blocked;

        n        = m;
        xi       = m.x;
        move     = 1'b0;
        go_right = 1'b0;
        if (m.gone)
            return n;
        if (m.dying)
        begin
            if (m.cnt + 1 == enemy_pkg::DEATH_TICKS)
            begin
                n.dying = 1'b0;
                n.gone  = 1'b1;
                n.x     = '0;
            end
            else
                n.cnt = m.cnt + 1;
            return n;
        end
        if (!alv)
        begin
            n.dying = 1'b1;
            n.cnt   = '0;
            return n;
        end
        if (xi <= int'(sx))
        begin
            move     = 1'b1;
            go_right = 1'b1;
        end
        else if (xi + enemy_pkg::SPRITE_SIZE >= X_LIM)
            move = 1'b1;
        else if (m.cnt + 1 == enemy_pkg::DWELL_TICKS)
        begin
            n.cnt  = '0;
            move   = 1'b1;
            dist_m = int'(mx) - xi;
            dist_l = int'(lx) - xi;
            if (dist_m < 0)
                dist_m = -dist_m;
            if (dist_l < 0)
                dist_l = -dist_l;
            // ties go to mario
            go_right = (dist_m <= dist_l) ? (int'(mx) >= xi) : (int'(lx) >= xi);
        end
        else
            n.cnt = m.cnt + 1;
        if (move)
        begin
            n.frame_b = !m.frame_b;
            blocked   = ((xi + 32 > 101) && (xi < 161)) || ((xi + 26 > 641) && (xi < 701));
            if (!blocked)
            begin
                if (go_right)
                    xi = (xi + enemy_pkg::STEP > X_LIM) ? X_LIM : xi + enemy_pkg::STEP;
                else
                    xi = (xi < enemy_pkg::STEP) ? 0 : xi - enemy_pkg::STEP;
                n.x = enemy_pkg::xcoord_t'(xi);
            end
        end
        return n;
    endfunction

    function automatic logic exp_hit(model_t m, enemy_pkg::xcoord_t dx, enemy_pkg::xcoord_t dy,
                                     enemy_pkg::xcoord_t sx);
        int world;

        world = int'(dx) + int'(sx);
        return !m.gone && (int'(m.x) < world) && (world < int'(m.x) + enemy_pkg::SPRITE_SIZE) &&
               (int'(dy) > int'(enemy_pkg::GROUND_Y)) &&
               (int'(dy) < int'(enemy_pkg::GROUND_Y) + enemy_pkg::SPRITE_SIZE);
    endfunction

    function automatic enemy_pkg::rgb_t exp_pixel(model_t m);
        if (m.gone)
            return '0;
        if (m.dying)
            return pic_dead;
        return m.frame_b ? pic_b : pic_a;
    endfunction

    task automatic check_x(string name, enemy_pkg::xcoord_t exp, enemy_pkg::xcoord_t act);
        n_checks++;
        if (act !== exp)
        begin
            n_errors++;
            $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_rgb(string name, enemy_pkg::rgb_t exp, enemy_pkg::rgb_t act);
        n_checks++;
        if (act !== exp)
        begin
            n_errors++;
            $display("[ERROR] %0t %s expected %06h actual %06h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        n_checks++;
        if (act !== exp)
        begin
            n_errors++;
            $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic apply_row(row_t r);
        @(posedge Clk);
        mario_x  <= r.mario;
        luigi_x  <= r.luigi;
        scroll_x <= r.scroll;
        alive    <= r.alive;
    endtask

    task automatic frame_step();
        @(posedge Clk);
        frame_tick <= 1'b1;
        m_main = next_model(m_main, mario_x, luigi_x, scroll_x, alive);
        m_lim  = next_model(m_lim, mario_x, luigi_x, scroll_x, alive);
        @(posedge Clk);
        frame_tick <= 1'b0;
        // new x is visible in the cycle after the tick
        @(negedge Clk);
        check_x("enemy_x", m_main.x, enemy_x);
        check_x("lim_x", m_lim.x, lim_x);
    endtask

    // hit and pixel are registered one cycle after the draw position
    task automatic read_pixel(enemy_pkg::xcoord_t dx, enemy_pkg::xcoord_t dy);
        @(posedge Clk);
        draw_x <= dx;
        draw_y <= dy;
        @(posedge Clk);
        @(negedge Clk);
        check_bit("hit", exp_hit(m_main, dx, dy, scroll_x), hit);
        check_rgb("pixel", exp_pixel(m_main), pixel);
    endtask

    task automatic read_centre();
        read_pixel(m_main.x + 10'd16 - scroll_x, 10'd400);
    endtask

    task automatic run_rows(int first, int last);
        int b_err;
        int b_chk;

        for (int i = first; i <= last; i++)
        begin
            b_err = n_errors;
            b_chk = n_checks;
            apply_row(rows[i]);
            repeat (rows[i].ticks)
            begin
                frame_step();
                read_centre();
            end
            $display("%s: %0d checks, %0d errors", row_name[i], n_checks - b_chk,
                     n_errors - b_err);
        end
    endtask

    task automatic load_table();
        rows[0] = '{10'd200, 10'd900, 10'd0,   1'b1, 10'd4};
        rows[1] = '{10'd100, 10'd420, 10'd0,   1'b1, 10'd4};
        rows[2] = '{10'd380, 10'd900, 10'd450, 1'b1, 10'd3};
        // long left walk until pipe 1 stops the enemy at 160
        rows[3] = '{10'd0,   10'd1000, 10'd0,  1'b1, 10'd500};
        rows[4] = '{10'd0,   10'd1000, 10'd0,  1'b1, 10'd8};
        rows[5] = '{10'd0,   10'd1000, 10'd0,  1'b0, 10'd1};
        rows[6] = '{10'd0,   10'd1000, 10'd0,  1'b0, 10'd4};
        row_name[0] = "chase_left";
        row_name[1] = "chase_right";
        row_name[2] = "scroll_edge";
        row_name[3] = "pipe_walk";
        row_name[4] = "pipe_hold";
        row_name[5] = "dying";
        row_name[6] = "gone";
    endtask

    initial
    begin
        int                 b_err;
        int                 b_chk;
        int                 off;
        int                 assert_fails;
        enemy_pkg::xcoord_t sx;
        enemy_pkg::xcoord_t dx;
        enemy_pkg::xcoord_t dy;
        row_t               r;

        void'($urandom(32'h4aa0bef7));
        load_table();
        n_checks   = 0;
        n_errors   = 0;
        rst_n      = 1'b0;
        frame_tick = 1'b0;
        alive      = 1'b1;
        mario_x    = '0;
        luigi_x    = '0;
        scroll_x   = '0;
        draw_x     = '0;
        draw_y     = '0;
        pic_a      = 24'($urandom);
        pic_b      = 24'($urandom);
        pic_dead   = 24'($urandom);
        m_main     = '0;
        m_main.x   = 10'd400;
        m_lim      = '0;
        m_lim.x    = 10'd1000;
        repeat (4) @(posedge Clk);
        rst_n <= 1'b1;

        @(negedge Clk);
        check_x("enemy_x", 10'd400, enemy_x);
        check_x("enemy_y", 10'd384, enemy_y);
        check_x("lim_x", 10'd1000, lim_x);
        read_centre();
        $display("reset: %0d checks, %0d errors", n_checks, n_errors);

        run_rows(0, 4);

        b_err = n_errors;
        b_chk = n_checks;
        repeat (40)
        begin
            sx  = 10'($urandom % 200);
            off = int'($urandom % 48) - 8;
            dx  = enemy_pkg::xcoord_t'(int'(m_main.x) + off - int'(sx));
            dy  = 10'(376 + $urandom % 48);
            @(posedge Clk);
            scroll_x <= sx;
            read_pixel(dx, dy);
        end
        $display("pixel_window: %0d checks, %0d errors", n_checks - b_chk, n_errors - b_err);

        run_rows(5, 6);

        b_err = n_errors;
        b_chk = n_checks;
        repeat (8)
        begin
            r.mario  = 10'($urandom);
            r.luigi  = 10'($urandom);
            r.scroll = 10'($urandom);
            r.alive  = 1'($urandom);
            r.ticks  = 10'd1;
            apply_row(r);
            frame_step();
            read_centre();
        end
        $display("after_gone: %0d checks, %0d errors", n_checks - b_chk, n_errors - b_err);

        assert_fails = dut.u_walker.u_walker_assert.fail_count +
                       dut_near_limit.u_walker.u_walker_assert.fail_count;
        if (assert_fails != 0)
            $display("%0d walker assertions failed during the run", assert_fails);
        n_errors += assert_fails;

        $display("total: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule
